// ==== scope.f ====
logic/audio_pkg.sv
logic/scope_pkg.sv
logic/sample_capture.sv
logic/trace_buffer.sv
logic/vga_timing.sv
logic/trace_renderer.sv
logic/peak_meter.sv
logic/scope_top.sv
verification/scope_tb.sv

// ==== Makefile ====
# Verilator flow for the scope display path

TOP = scope_tb

.PHONY: sim lint clean

sim:
	verilator --binary --timing -Wno-fatal -f scope.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^all tests passed$$" sim.log

lint:
	verilator --lint-only --timing -f scope.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== verification/scope_tb.sv ====
module scope_tb;

  localparam int H_ACTIVE      = 64;
  localparam int H_FRONT       = 4;
  localparam int H_SYNC        = 8;
  localparam int H_BACK        = 4;
  localparam int V_ACTIVE      = 48;
  localparam int V_FRONT       = 2;
  localparam int V_SYNC        = 2;
  localparam int V_BACK        = 2;
  localparam int SCALE_SHIFT   = 7;
  localparam int H_TOTAL       = H_ACTIVE + H_FRONT + H_SYNC + H_BACK; // 80 clocks per line
  localparam int V_TOTAL       = V_ACTIVE + V_FRONT + V_SYNC + V_BACK; // 54 lines per frame
  localparam int FRAME_CLKS    = H_TOTAL * V_TOTAL;
  localparam int WATCHDOG_CLKS = 12 * FRAME_CLKS; // Full run takes about seven frames

  logic               clk;
  logic               rst_n;
  logic               aud_lrck;
  audio_pkg::sample_t aud_in;
  logic [3:0]         volume;
  audio_pkg::sample_t aud_out;
  scope_pkg::rgb_t    vga_rgb;
  scope_pkg::raster_t vga_sync;
  logic [6:0]         hex0;
  logic [6:0]         hex1;
  logic [6:0]         hex2;
  logic [6:0]         hex3;

  int errors;
  int errs_before; // Error count when the current test began
  int checks;
  int tests_run;
  int tests_bad;

  // Active-low digit patterns 0..F with bit 0 as segment a
  logic [6:0] seg_tbl [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                               7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};

  scope_top #(
    .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
    .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK),
    .SCALE_SHIFT (SCALE_SHIFT)
  ) UUT (
    .clk (clk), .rst_n (rst_n), .aud_lrck (aud_lrck), .aud_in (aud_in), .volume (volume),
    .aud_out (aud_out), .vga_rgb (vga_rgb), .vga_sync (vga_sync),
    .hex0 (hex0), .hex1 (hex1), .hex2 (hex2), .hex3 (hex3)
  );

  always #2 clk = ~clk; // Period 4

  initial begin
    repeat (WATCHDOG_CLKS) @(posedge clk);
    $display("watchdog expired after %0d clocks, the run did not finish", WATCHDOG_CLKS);
    $display("tests failed");
    $finish;
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("ERR %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - errs_before);
    end
    errs_before = errors;
  endtask

  function automatic int floor_div(input int num, input int den);
    int q;
    q = num / den;
    if ((num % den != 0) && (num < 0)) q = q - 1; // Round toward minus infinity
    return q;
  endfunction

  function automatic int expected_row(input audio_pkg::sample_t s);
    int row;
    row = V_ACTIVE / 2 - floor_div(int'(s), 1 << SCALE_SHIFT); // Up is positive
    if (row < 0) row = 0;
    if (row > V_ACTIVE - 1) row = V_ACTIVE - 1;
    return row;
  endfunction

  // One LR period with the word held across the high phase
  task automatic feed_sample(input audio_pkg::sample_t s);
    @(posedge clk);
    aud_in   <= s;
    aud_lrck <= 1'b1;
    repeat (4) @(posedge clk);
    aud_lrck <= 1'b0;
    repeat (3) @(posedge clk); // Next call adds the fourth low cycle
  endtask

  task automatic wait_vs_fall();
    @(negedge clk);
    while (vga_sync.vs_n !== 1'b1) @(negedge clk);
    while (vga_sync.vs_n !== 1'b0) @(negedge clk);
  endtask

  task automatic check_digits(input string name, input int value);
    check(name, 32'(seg_tbl[4'(value)]), 32'(hex0));
    check(name, 32'(seg_tbl[4'(value >> 4)]), 32'(hex1));
    check(name, 32'(seg_tbl[4'(value >> 8)]), 32'(hex2));
    check(name, 32'(seg_tbl[4'(value >> 12)]), 32'(hex3));
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    check("reset_state sync", 32'(3'b110), 32'(vga_sync)); // Syncs high and picture blanked
    check("reset_state rgb", 0, 32'(vga_rgb));
    check("reset_state aud_out", 0, 32'(aud_out));
    check_digits("reset_state hex", 0);
    end_test("reset_state");
  endtask

  task automatic test_raster_timing();
    int   cycles;
    int   hs_len;
    int   bl_len;
    int   bl_lines;
    logic vs_prev;
    wait_vs_fall();
    cycles   = 0;
    hs_len   = 0;
    bl_len   = 0;
    bl_lines = 0;
    do begin
      vs_prev = vga_sync.vs_n;
      @(negedge clk);
      cycles++;
      if (!vga_sync.hs_n) begin
        hs_len++;
      end else if (hs_len != 0) begin // Pulse just ended
        check("raster_timing hs_n low", H_SYNC, hs_len);
        hs_len = 0;
      end
      if (vga_sync.blank_n) begin
        bl_len++;
      end else begin
        if (bl_len != 0) begin
          check("raster_timing blank_n high", H_ACTIVE, bl_len);
          bl_lines++;
          bl_len = 0;
        end
        check("raster_timing blank rgb", 0, 32'(vga_rgb));
      end
    end while (!(vs_prev && !vga_sync.vs_n));
    check("raster_timing frame clocks", FRAME_CLKS, cycles);
    check("raster_timing active lines", V_ACTIVE, bl_lines);
    end_test("raster_timing");
  endtask

  task automatic test_volume_loopback();
    audio_pkg::sample_t s;
    logic [3:0]         v;
    int                 i;
    for (i = 0; i < 20; i++) begin
      // Non-negative half first so no zero crossing arms a record here
      s = audio_pkg::sample_t'({i >= 10, 15'($urandom)});
      v = 4'($urandom);
      @(posedge clk);
      volume <= v;
      feed_sample(s);
      @(negedge clk);
      check("volume_loopback", 32'(floor_div(int'(s), 1 << v)), 32'(aud_out));
    end
    end_test("volume_loopback");
  endtask

  task automatic test_trigger_trace();
    audio_pkg::sample_t seq [$];
    audio_pkg::sample_t captured [H_ACTIVE];
    int                 hits [H_ACTIVE];
    int                 rows [H_ACTIVE];
    int                 col;
    int                 i;
    int                 x;
    int                 y;
    seq.push_back(-16'sd300);
    seq.push_back(16'sd0); // Rising crossing
    for (i = 0; i < H_ACTIVE; i++) seq.push_back(16'(64 * i - 2000));
    col = -1;
    for (i = 1; i < seq.size(); i++) begin // Record model starts armed
      if (col < 0 && seq[i-1] < 0 && seq[i] >= 0) col = 0;
      if (col >= 0 && col < H_ACTIVE) begin
        captured[col] = seq[i];
        col++;
      end
    end
    for (i = 0; i < seq.size(); i++) feed_sample(seq[i]);
    wait_vs_fall();
    wait_vs_fall();
    for (i = 0; i < H_ACTIVE; i++) hits[i] = 0;
    for (y = 0; y < V_ACTIVE; y++) begin
      @(negedge clk);
      while (!vga_sync.blank_n) @(negedge clk); // Line starts at blank_n rise
      for (x = 0; x < H_ACTIVE; x++) begin
        if (vga_rgb == scope_pkg::TRACE_COLOR) begin
          hits[x]++;
          rows[x] = y;
        end
        @(negedge clk);
      end
    end
    for (x = 0; x < H_ACTIVE; x++) begin
      check($sformatf("trigger_trace col %0d hits", x), 1, hits[x]);
      if (hits[x] == 1) begin
        check($sformatf("trigger_trace col %0d row", x), expected_row(captured[x]), rows[x]);
      end
    end
    end_test("trigger_trace");
  endtask

  task automatic test_peak_meter();
    audio_pkg::sample_t vals [5];
    int                 peak;
    int                 mag;
    int                 i;
    vals = '{16'sd1200, -16'sd9000, 16'sd7000, -16'sd4500, 16'sd300};
    peak = 0;
    wait_vs_fall(); // Well clear of the next frame start
    for (i = 0; i < 5; i++) begin
      feed_sample(vals[i]);
      mag = (vals[i] < 0) ? -int'(vals[i]) : int'(vals[i]);
      if (mag > peak) peak = mag;
    end
    wait_vs_fall();
    check_digits("peak_meter peak", peak); // 9000 reads 2328
    wait_vs_fall(); // One frame with no samples
    check_digits("peak_meter cleared", 0);
    end_test("peak_meter");
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    aud_lrck    = 1'b0;
    aud_in      = '0;
    volume      = '0;
    errors      = 0;
    errs_before = 0;
    checks      = 0;
    tests_run   = 0;
    tests_bad   = 0;
    void'($urandom(32'hce47));
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_state();
    test_raster_timing();
    test_volume_loopback();
    test_trigger_trace();
    test_peak_meter();
    $display("summary: %0d tests run, %0d with errors, %0d errors in %0d checks",
             tests_run, tests_bad, errors, checks);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== logic/scope_top.sv ====
module scope_top #(
  parameter int H_ACTIVE    = 640,
  parameter int H_FRONT     = 16,
  parameter int H_SYNC      = 96,
  parameter int H_BACK      = 48,
  parameter int V_ACTIVE    = 480,
  parameter int V_FRONT     = 10,
  parameter int V_SYNC      = 2,
  parameter int V_BACK      = 33,
  parameter int SCALE_SHIFT = 7
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               aud_lrck,
  input  audio_pkg::sample_t aud_in,
  input  logic [3:0]         volume,
  output audio_pkg::sample_t aud_out,
  output scope_pkg::rgb_t    vga_rgb,
  output scope_pkg::raster_t vga_sync,
  output logic [6:0]         hex0,
  output logic [6:0]         hex1,
  output logic [6:0]         hex2,
  output logic [6:0]         hex3
);

  audio_pkg::sample_evt_t sample_evt;  // Capture to buffer and meter
  scope_pkg::pixel_pos_t  pos;
  scope_pkg::raster_t     timing;
  logic                   active;
  logic                   frame_start; // Shared frame boundary
  logic [9:0]             rd_col;
  audio_pkg::sample_t     rd_sample;
  logic                   rd_ok;

  sample_capture u_capture (
    .clk        (clk),
    .rst_n      (rst_n),
    .aud_lrck   (aud_lrck),
    .aud_in     (aud_in),
    .volume     (volume),
    .sample_evt (sample_evt),
    .aud_out    (aud_out)
  );

  trace_buffer #(
    .DEPTH (H_ACTIVE) // One sample per visible column
  ) u_buffer (
    .clk         (clk),
    .rst_n       (rst_n),
    .sample_evt  (sample_evt),
    .frame_start (frame_start),
    .rd_col      (rd_col),
    .rd_sample   (rd_sample),
    .rd_ok       (rd_ok)
  );

  vga_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) u_timing (
    .clk         (clk),
    .rst_n       (rst_n),
    .pos         (pos),
    .timing      (timing),
    .active      (active),
    .frame_start (frame_start)
  );

  trace_renderer #(
    .V_ACTIVE    (V_ACTIVE),
    .SCALE_SHIFT (SCALE_SHIFT)
  ) u_renderer (
    .clk       (clk),
    .rst_n     (rst_n),
    .pos       (pos),
    .timing    (timing),
    .active    (active),
    .rd_sample (rd_sample),
    .rd_ok     (rd_ok),
    .rd_col    (rd_col),
    .vga_rgb   (vga_rgb),
    .vga_sync  (vga_sync)
  );

  peak_meter u_meter (
    .clk         (clk),
    .rst_n       (rst_n),
    .sample_evt  (sample_evt),
    .frame_start (frame_start),
    .hex0        (hex0),
    .hex1        (hex1),
    .hex2        (hex2),
    .hex3        (hex3)
  );

endmodule

// ==== logic/peak_meter.sv ====
module peak_meter (
  input  logic                   clk,
  input  logic                   rst_n,
  input  audio_pkg::sample_evt_t sample_evt,
  input  logic                   frame_start, // Latch and restart point
  output logic [6:0]             hex0,        // Lowest nibble
  output logic [6:0]             hex1,
  output logic [6:0]             hex2,
  output logic [6:0]             hex3         // Highest nibble
);

  audio_pkg::mag_t cur_mag;   // Magnitude of the incoming sample
  audio_pkg::mag_t peak;      // Running maximum this frame
  audio_pkg::mag_t peak_next;
  audio_pkg::mag_t disp;      // Value on the digits

  // Negation of -32768 wraps to 16'h8000, the saturated magnitude
  assign cur_mag = sample_evt.data[15] ? audio_pkg::mag_t'(-sample_evt.data)
                                       : audio_pkg::mag_t'(sample_evt.data);

  assign peak_next = (sample_evt.valid && (cur_mag > peak)) ? cur_mag : peak;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      peak <= '0;
      disp <= '0; // Digits read 0000
    end else if (frame_start) begin
      disp <= peak_next; // Includes a sample on this same cycle
      peak <= '0;
    end else begin
      peak <= peak_next;
    end
  end

  // Active-low segments, bit 0 is a, bit 6 is g
  function automatic logic [6:0] seg7(input logic [3:0] nib);
    case (nib)
      4'h0:    seg7 = ~7'h3f;
      4'h1:    seg7 = ~7'h06;
      4'h2:    seg7 = ~7'h5b;
      4'h3:    seg7 = ~7'h4f;
      4'h4:    seg7 = ~7'h66;
      4'h5:    seg7 = ~7'h6d;
      4'h6:    seg7 = ~7'h7d;
      4'h7:    seg7 = ~7'h07;
      4'h8:    seg7 = ~7'h7f;
      4'h9:    seg7 = ~7'h6f;
      4'ha:    seg7 = ~7'h77;
      4'hb:    seg7 = ~7'h7c; // Lower case b
      4'hc:    seg7 = ~7'h39;
      4'hd:    seg7 = ~7'h5e; // Lower case d
      4'he:    seg7 = ~7'h79;
      default: seg7 = ~7'h71; // F
    endcase
  endfunction

  assign hex0 = seg7(disp[3:0]);
  assign hex1 = seg7(disp[7:4]);
  assign hex2 = seg7(disp[11:8]);
  assign hex3 = seg7(disp[15:12]);

endmodule

// ==== logic/trace_renderer.sv ====
module trace_renderer #(
  parameter int V_ACTIVE    = 480,
  parameter int SCALE_SHIFT = 7 // Sample LSBs dropped per screen row
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  scope_pkg::pixel_pos_t pos,
  input  scope_pkg::raster_t    timing,
  input  logic                  active,
  input  audio_pkg::sample_t    rd_sample, // Sample for pos_d.x
  input  logic                  rd_ok,
  output logic [9:0]            rd_col,
  output scope_pkg::rgb_t       vga_rgb,
  output scope_pkg::raster_t    vga_sync
);

  localparam logic signed [17:0] ROW_MID = 18'(V_ACTIVE / 2); // Zero level
  localparam logic signed [17:0] ROW_MAX = 18'(V_ACTIVE - 1);

  scope_pkg::pixel_pos_t pos_d;    // Position aligned to rd_sample
  scope_pkg::raster_t    timing_d;
  logic                  active_d;
  audio_pkg::sample_t    scaled;
  logic signed [17:0]    row_raw;  // Unclamped trace row
  logic [9:0]            trace_row;
  logic                  on_grid;
  scope_pkg::rgb_t       pixel;

  assign rd_col = pos.x; // Column address straight to the buffer

  // First stage waits for the buffer read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      timing_d <= scope_pkg::RASTER_IDLE;
      active_d <= 1'b0;
    end else begin
      timing_d <= timing;
      active_d <= active;
    end
  end

  always_ff @(posedge clk) begin
    pos_d <= pos;
  end

  assign scaled  = rd_sample >>> SCALE_SHIFT;
  assign row_raw = ROW_MID - 18'(scaled); // Positive samples draw upward

  always_comb begin
    if (row_raw[17]) begin
      trace_row = '0;             // Above the top edge
    end else if (row_raw > ROW_MAX) begin
      trace_row = ROW_MAX[9:0];   // Below the bottom edge
    end else begin
      trace_row = row_raw[9:0];
    end
  end

  assign on_grid = (pos_d.y == ROW_MID[9:0]) || ((pos_d.x % scope_pkg::GRID_STEP) == 0);

  always_comb begin
    if (!active_d) begin
      pixel = scope_pkg::BG_COLOR;    // Blanking interval
    end else if (rd_ok && (pos_d.y == trace_row)) begin
      pixel = scope_pkg::TRACE_COLOR; // Trace wins over grid
    end else if (on_grid) begin
      pixel = scope_pkg::GRID_COLOR;
    end else begin
      pixel = scope_pkg::BG_COLOR;
    end
  end

  // Second stage, colour and sync leave together
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vga_rgb  <= '0;
      vga_sync <= scope_pkg::RASTER_IDLE;
    end else begin
      vga_rgb  <= pixel;
      vga_sync <= timing_d;
    end
  end

endmodule

// ==== logic/vga_timing.sv ====
module vga_timing #(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  logic                  clk,
  input  logic                  rst_n,
  output scope_pkg::pixel_pos_t pos,        // Current counter position
  output scope_pkg::raster_t    timing,     // Syncs and blank for pos
  output logic                  active,     // pos is in the visible area
  output logic                  frame_start // High at (0,0) after a wrap
);

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  localparam logic [9:0] H_LAST   = 10'(H_TOTAL - 1);
  localparam logic [9:0] V_LAST   = 10'(V_TOTAL - 1);
  localparam logic [9:0] HS_START = 10'(H_ACTIVE + H_FRONT);
  localparam logic [9:0] HS_END   = 10'(H_ACTIVE + H_FRONT + H_SYNC);
  localparam logic [9:0] VS_START = 10'(V_ACTIVE + V_FRONT);
  localparam logic [9:0] VS_END   = 10'(V_ACTIVE + V_FRONT + V_SYNC);

  logic [9:0] h_cnt;
  logic [9:0] v_cnt;
  logic       h_last;
  logic       v_last;
  logic       hs_on;
  logic       vs_on;

  assign h_last = (h_cnt == H_LAST);
  assign v_last = (v_cnt == V_LAST);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_cnt       <= '0;
      v_cnt       <= '0;
      frame_start <= 1'b0;
    end else begin
      frame_start <= h_last && v_last; // Marks the wrap, not the reset
      if (h_last) begin
        h_cnt <= '0;
        v_cnt <= v_last ? '0 : v_cnt + 10'd1; // Next line or next frame
      end else begin
        h_cnt <= h_cnt + 10'd1;
      end
    end
  end

  assign hs_on  = (h_cnt >= HS_START) && (h_cnt < HS_END);
  assign vs_on  = (v_cnt >= VS_START) && (v_cnt < VS_END); // Whole lines
  assign active = (h_cnt < 10'(H_ACTIVE)) && (v_cnt < 10'(V_ACTIVE));

  assign pos    = '{x: h_cnt, y: v_cnt};
  assign timing = '{hs_n: !hs_on, vs_n: !vs_on, blank_n: active};

endmodule

// ==== logic/trace_buffer.sv ====
module trace_buffer #(
  parameter int DEPTH = 640 // One screen width of samples
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  audio_pkg::sample_evt_t sample_evt,
  input  logic                   frame_start, // Re-arm point when frozen
  input  logic [9:0]             rd_col,      // Column being drawn
  output audio_pkg::sample_t     rd_sample,   // One cycle after rd_col
  output logic                   rd_ok        // A full record exists
);

  localparam int            AW   = $clog2(DEPTH);
  localparam logic [AW-1:0] LAST = AW'(DEPTH - 1);

  typedef enum logic [1:0] {
    ARMED,     // Watching for a rising zero crossing
    CAPTURING, // Filling the record
    FROZEN     // Record complete, held for display
  } state_t;

  state_t             state;
  audio_pkg::sample_t prev;    // Last sample seen, for the crossing test
  logic [AW-1:0]      wr_addr;
  logic               trigger;
  logic               wr_en;
  logic [AW-1:0]      wr_sel;

  audio_pkg::sample_t mem [DEPTH];

  // Negative to non-negative step starts a record
  assign trigger = (state == ARMED) && sample_evt.valid && prev[15] && !sample_evt.data[15];
  assign wr_en   = trigger || ((state == CAPTURING) && sample_evt.valid);
  assign wr_sel  = trigger ? '0 : wr_addr; // Trigger sample lands at column 0

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_sel] <= sample_evt.data;
    end
    rd_sample <= mem[rd_col[AW-1:0]]; // Registered read port
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= ARMED;
      prev    <= '0; // Non-negative, no false trigger on first sample
      wr_addr <= '0;
      rd_ok   <= 1'b0;
    end else begin
      if (sample_evt.valid) begin
        prev <= sample_evt.data; // Tracked in every state
      end
      case (state)
        ARMED: begin
          if (trigger) begin
            state   <= CAPTURING;
            wr_addr <= AW'(1);
          end
        end
        CAPTURING: begin
          if (sample_evt.valid) begin
            wr_addr <= wr_addr + AW'(1);
            if (wr_addr == LAST) begin // Last column written
              state <= FROZEN;
              rd_ok <= 1'b1;           // Sticky from here on
            end
          end
        end
        FROZEN: begin
          if (frame_start) begin
            state <= ARMED; // Memory kept until next trigger
          end
        end
        default: state <= ARMED;
      endcase
    end
  end

endmodule

// ==== logic/sample_capture.sv ====
module sample_capture (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   aud_lrck,   // Codec LR clock, async level
  input  audio_pkg::sample_t     aud_in,     // Held stable across capture
  input  logic [3:0]             volume,     // Attenuation as right shift
  output audio_pkg::sample_evt_t sample_evt,
  output audio_pkg::sample_t     aud_out     // Scaled copy for playback
);

  logic [1:0] lrck_sync; // Two-flop synchronizer
  logic       lrck_d;    // Previous synced level
  logic       lrck_rise;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lrck_sync <= '0;
      lrck_d    <= 1'b0;
    end else begin
      lrck_sync <= {lrck_sync[0], aud_lrck}; // Shift in raw level
      lrck_d    <= lrck_sync[1];
    end
  end

  assign lrck_rise = lrck_sync[1] & ~lrck_d; // Rising edge of synced level

  // Event and playback word leave on the third edge after the LR rise
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sample_evt <= '0;
      aud_out    <= '0;
    end else begin
      sample_evt.valid <= lrck_rise; // Single-cycle strobe
      if (lrck_rise) begin
        sample_evt.data <= aud_in;
        aud_out         <= aud_in >>> volume; // Arithmetic, keeps sign
      end
    end
  end

endmodule

// ==== logic/scope_pkg.sv ====
package scope_pkg;

  // Raster coordinate, x is column and y is row
  typedef struct packed {
    logic [9:0] x;
    logic [9:0] y;
  } pixel_pos_t;

  // 24-bit colour, one byte per DAC channel
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  // VGA control lines, all active low
  typedef struct packed {
    logic hs_n;    // Horizontal sync
    logic vs_n;    // Vertical sync
    logic blank_n; // Low outside the visible area
  } raster_t;

  // Syncs released, picture blanked
  localparam raster_t RASTER_IDLE = '{hs_n: 1'b1, vs_n: 1'b1, blank_n: 1'b0};

  localparam rgb_t TRACE_COLOR = '{r: 8'h00, g: 8'hff, b: 8'h00}; // Pure green
  localparam rgb_t GRID_COLOR  = '{r: 8'h40, g: 8'h40, b: 8'h40}; // Dim grey
  localparam rgb_t BG_COLOR    = '{r: 8'h00, g: 8'h00, b: 8'h00}; // Black

  localparam int GRID_STEP = 16; // Pixels between vertical grid lines

endpackage

// ==== logic/audio_pkg.sv ====
package audio_pkg;

  // One codec word, two's complement
  typedef logic signed [15:0] sample_t;

  // Unsigned magnitude, -32768 folds to 16'h8000
  typedef logic [15:0] mag_t;

  // New-sample strobe with its payload
  typedef struct packed {
    logic    valid; // High for one clk per LR rise
    sample_t data;  // Latched codec word
  } sample_evt_t;

endpackage
